//--- sim/datapath_testdata.txt
# loads: rIn hiIn loIn yIn zIn pcIn mdrIn irIn read | selects: gra grb grc
# drives: rOut hiOut loOut zHighOut zLowOut pcOut mdrOut inPortOut cOut | inPortStrobe aluOp memDataIn inPortData busData
000000000 000 000000000 0 0 00000000 00000000 00000000
000000001 000 000000000 1 0 00918000 11111111 00000000
000000010 000 000000100 0 0 00000000 00000000 00918000
000000000 000 000000000 0 0 00000000 00000000 00018000
100000000 100 000000010 1 0 00000000 22222222 11111111
100000000 010 000000010 1 0 00000000 00000004 22222222
100000000 001 000000010 1 0 00000000 FFFFFFF0 00000004
000100000 000 000000010 0 0 00000000 00000000 FFFFFFF0
000000000 100 100000000 0 0 00000000 00000000 11111111
000000000 010 100000000 0 0 00000000 00000000 22222222
000000000 001 100000000 0 0 00000000 00000000 00000004
000000000 110 100000000 0 0 00000000 00000000 11111111
000000000 011 100000000 0 0 00000000 00000000 22222222
000000000 100 100000110 0 0 00000000 00000000 FFFFFFF0
000000000 100 100000100 0 0 00000000 00000000 00918000
000000000 100 100001000 0 0 00000000 00000000 00000000
000000000 100 111111111 0 0 00000000 00000000 00018000
000000000 100 110000000 0 0 00000000 00000000 00000000
000010000 001 100000000 0 0 00000000 00000000 00000004
000000000 000 000010000 0 0 00000000 00000000 FFFFFFF4
000000000 000 000100000 0 0 00000000 00000000 FFFFFFFF
000010000 001 100000000 0 1 00000000 00000000 00000004
000000000 000 000010000 0 0 00000000 00000000 FFFFFFEC
000010000 100 100000000 0 2 00000000 00000000 11111111
000000000 000 000010000 0 0 00000000 00000000 11111110
000010000 010 100000000 0 3 00000000 00000000 22222222
000000000 000 000010000 0 0 00000000 00000000 FFFFFFF2
000010000 001 100000000 0 4 00000000 00000000 00000004
000000000 000 000010000 0 0 00000000 00000000 0FFFFFFF
000010000 001 100000000 0 5 00000000 00000000 00000004
000000000 000 000010000 0 0 00000000 00000000 FFFFFFFF
000010000 001 100000000 0 6 00000000 00000000 00000004
000000000 000 000010000 0 0 00000000 00000000 FFFFFF00
000010000 010 100000000 0 7 00000000 00000000 22222222
000000000 000 000010000 0 0 00000000 00000000 3FFFFFFC
000010000 001 100000000 0 8 00000000 00000000 00000004
000000000 000 000010000 0 0 00000000 00000000 FFFFFF0F
000010000 100 100000000 0 9 00000000 00000000 11111111
001000000 000 000010000 0 0 00000000 00000000 EEEEEEF0
010000000 000 000100000 0 0 00000000 00000000 FFFFFFFE
000000000 000 010000000 0 0 00000000 00000000 FFFFFFFE
000000000 000 001000000 0 0 00000000 00000000 EEEEEEF0
000010000 010 100000000 0 A 00000000 00000000 22222222
000000000 000 000010000 0 0 00000000 00000000 DDDDDDDE
000000000 000 000100000 0 0 00000000 00000000 FFFFFFFF
000010000 001 100000000 0 B 00000000 00000000 00000004
000000000 000 000010000 0 0 00000000 00000000 FFFFFFFB
000000001 000 000000000 0 0 0007FFF0 00000000 00018000
000000010 000 000000100 0 0 00000000 00000000 0007FFF0
000000000 000 000000000 0 0 00000000 00000000 FFFFFFF0
000000001 000 000000001 0 0 0003ABCD 00000000 FFFFFFF0
000000010 000 000000100 0 0 00000000 00000000 0003ABCD
000000000 000 000000000 1 0 00000000 00001000 0003ABCD
000001000 000 000000010 0 0 00000000 00000000 00001000
000000101 000 000001000 0 0 ABCD1234 00000000 00001000
000000000 000 000000100 0 0 00000000 00000000 ABCD1234
000000100 000 000001000 0 0 00000000 00000000 00001000
000000000 000 000000100 0 0 00000000 00000000 00001000

//--- project.f
hdl/datapathPkg.sv
hdl/registerFile.sv
hdl/specialRegisters.sv
hdl/arithmeticUnit.sv
hdl/busMultiplexer.sv
hdl/datapathTop.sv
sim/datapath_assertions.sv
sim/datapathTb.sv

//--- runSim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module datapathTb -f project.f -o datapathSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/datapathSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1

//--- sim/datapathTb.sv
module datapathTb;

    localparam int    clockPeriod = 40;
    localparam int    resetCycles = 5;
    localparam string dataPath    = "sim/datapath_testdata.txt";

    logic clock;
    logic reset;
    logic rIn, hiIn, loIn, yIn, zIn, pcIn, mdrIn, irIn, read;
    logic gra, grb, grc;
    logic rOut, hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut;
    logic inPortStrobe;
    datapathPkg::aluOp_t aluOp;
    datapathPkg::word_t  memDataIn;
    datapathPkg::word_t  inPortData;
    datapathPkg::word_t  busData;

    // one entry per data file line
    logic [8:0]         loadQ [$];
    logic [2:0]         selectQ [$];
    logic [8:0]         driveQ [$];
    logic               strobeQ [$];
    logic [3:0]         opQ [$];
    datapathPkg::word_t memQ [$];
    datapathPkg::word_t portQ [$];
    datapathPkg::word_t expectQ [$];
    logic               fileLoaded = 1'b0;

    datapathTop #(
        .regCount (16)
    ) i_dut (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stopOnFailure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic checkBusWord(input datapathPkg::word_t expected);
        if (busData !== expected)
            stopOnFailure($sformatf("FAIL at time %0t: busData expected %h, got %h",
                $time, expected, busData));
    endtask

    task automatic loadTestData();
        int                 fd;
        int                 fields;
        string              line;
        logic [8:0]         loads;
        logic [2:0]         selects;
        logic [8:0]         drives;
        logic               strobe;
        logic [3:0]         op;
        datapathPkg::word_t mem;
        datapathPkg::word_t port;
        datapathPkg::word_t expected;
        fd = $fopen(dataPath, "r");
        if (fd == 0)
            stopOnFailure("cannot open the test data file sim/datapath_testdata.txt");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            // comment lines and blank lines carry no stimulus
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            fields = $sscanf(line, "%b %b %b %b %h %h %h %h",
                loads, selects, drives, strobe, op, mem, port, expected);
            if (fields != 8)
                stopOnFailure($sformatf("test data line has too few columns: %s", line));
            loadQ.push_back(loads);
            selectQ.push_back(selects);
            driveQ.push_back(drives);
            strobeQ.push_back(strobe);
            opQ.push_back(op);
            memQ.push_back(mem);
            portQ.push_back(port);
            expectQ.push_back(expected);
        end
        $fclose(fd);
        if (expectQ.size() == 0)
            stopOnFailure("the test data file holds no stimulus lines");
    endtask

    task automatic driveLine(input int index);
        {rIn, hiIn, loIn, yIn, zIn, pcIn, mdrIn, irIn, read} = loadQ[index];
        {gra, grb, grc} = selectQ[index];
        {rOut, hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut} = driveQ[index];
        inPortStrobe = strobeQ[index];
        aluOp        = datapathPkg::aluOp_t'(opQ[index]);
        memDataIn    = memQ[index];
        inPortData   = portQ[index];
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clock, watchdog and stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    // each line takes one cycle, so twice that plus reset is a safe bound
    initial
    begin
        wait (fileLoaded);
        #(expectQ.size() * 2 * clockPeriod + (resetCycles + 1) * clockPeriod);
        stopOnFailure("watchdog expired before every test data line was checked");
    end

    initial
    begin
        wait (i_dut.i_assertions.failureCount != 0);
        stopOnFailure("an assertion on the bus selection or the reset state failed");
    end

    initial
    begin
        reset = 1'b1;
        {rIn, hiIn, loIn, yIn, zIn, pcIn, mdrIn, irIn, read} = '0;
        {gra, grb, grc} = '0;
        {rOut, hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut} = '0;
        inPortStrobe = 1'b0;
        aluOp        = datapathPkg::opAdd;
        memDataIn    = '0;
        inPortData   = '0;
        loadTestData();
        fileLoaded = 1'b1;
        repeat (resetCycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // the bus is combinational, so it settles well before the next rising edge
        for (int i = 0; i < expectQ.size(); i++)
        begin
            driveLine(i);
            #1;
            checkBusWord(expectQ[i]);
            @(negedge clock);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- sim/datapath_assertions.sv
module datapath_assertions (
    input logic               clock,
    input logic               reset,
    input logic               cOut,
    input logic               inPortOut,
    input logic               mdrOut,
    input logic               pcOut,
    input logic               zLowOut,
    input logic               zHighOut,
    input logic               loOut,
    input logic               hiOut,
    input logic               regDrive,
    input datapathPkg::word_t busData,
    input datapathPkg::word_t constWord
);

    logic anyDrive;
    int   failureCount = 0;

    assign anyDrive = cOut | inPortOut | mdrOut | pcOut | zLowOut | zHighOut
                    | loOut | hiOut | regDrive;

    // with no driver enabled the bus falls back to the IR constant
    idleBusIsConstant: assert property (@(posedge clock) disable iff (reset)
        !anyDrive |-> busData == constWord)
    else
    begin
        failureCount++;
        $error("bus differs from the IR constant while no driver is enabled");
    end

    // every register is clear one cycle after reset, so every source reads zero
    resetClearsBus: assert property (@(posedge clock) reset |=> busData == '0)
    else
    begin
        failureCount++;
        $error("bus is not zero one cycle after reset");
    end

    busNeverUnknown: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(busData))
    else
    begin
        failureCount++;
        $error("bus carries unknown bits");
    end

endmodule

bind datapathTop datapath_assertions i_assertions (
    .clock     (clock),
    .reset     (reset),
    .cOut      (cOut),
    .inPortOut (inPortOut),
    .mdrOut    (mdrOut),
    .pcOut     (pcOut),
    .zLowOut   (zLowOut),
    .zHighOut  (zHighOut),
    .loOut     (loOut),
    .hiOut     (hiOut),
    .regDrive  (regDrive),
    .busData   (busData),
    .constWord (constWord)
);

//--- hdl/datapathTop.sv
module datapathTop #(
    parameter int regCount = 16
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                rIn,
    input  logic                hiIn,
    input  logic                loIn,
    input  logic                yIn,
    input  logic                zIn,
    input  logic                pcIn,
    input  logic                mdrIn,
    input  logic                irIn,
    input  logic                read,
    input  logic                gra,
    input  logic                grb,
    input  logic                grc,
    input  logic                rOut,
    input  logic                hiOut,
    input  logic                loOut,
    input  logic                zHighOut,
    input  logic                zLowOut,
    input  logic                pcOut,
    input  logic                mdrOut,
    input  logic                inPortOut,
    input  logic                cOut,
    input  datapathPkg::aluOp_t aluOp,
    input  datapathPkg::word_t  memDataIn,
    input  datapathPkg::word_t  inPortData,
    input  logic                inPortStrobe,
    output datapathPkg::word_t  busData
);

    datapathPkg::instrWord_t irWord;
    datapathPkg::wideWord_t  aluResult;
    datapathPkg::word_t      regWord;
    datapathPkg::word_t      hiWord;
    datapathPkg::word_t      loWord;
    datapathPkg::word_t      zHighWord;
    datapathPkg::word_t      zLowWord;
    datapathPkg::word_t      pcWord;
    datapathPkg::word_t      mdrWord;
    datapathPkg::word_t      inPortWord;
    datapathPkg::word_t      yWord;
    datapathPkg::word_t      constWord;
    logic                    regDrive;

    registerFile #(
        .regCount (regCount)
    ) i_registerFile (
        .clock    (clock),
        .reset    (reset),
        .rIn      (rIn),
        .rOut     (rOut),
        .gra      (gra),
        .grb      (grb),
        .grc      (grc),
        .irWord   (irWord),
        .busWord  (busData),
        .regWord  (regWord),
        .regDrive (regDrive)
    );

    specialRegisters i_specialRegisters (
        .clock        (clock),
        .reset        (reset),
        .hiIn         (hiIn),
        .loIn         (loIn),
        .yIn          (yIn),
        .zIn          (zIn),
        .pcIn         (pcIn),
        .mdrIn        (mdrIn),
        .irIn         (irIn),
        .read         (read),
        .inPortStrobe (inPortStrobe),
        .busWord      (busData),
        .memDataIn    (memDataIn),
        .inPortData   (inPortData),
        .aluResult    (aluResult),
        .hiWord       (hiWord),
        .loWord       (loWord),
        .zHighWord    (zHighWord),
        .zLowWord     (zLowWord),
        .pcWord       (pcWord),
        .mdrWord      (mdrWord),
        .inPortWord   (inPortWord),
        .yWord        (yWord),
        .constWord    (constWord),
        .irWord       (irWord)
    );

    arithmeticUnit i_arithmeticUnit (
        .aluOp     (aluOp),
        .yWord     (yWord),
        .busWord   (busData),
        .aluResult (aluResult)
    );

    busMultiplexer i_busMultiplexer (
        .cOut       (cOut),
        .inPortOut  (inPortOut),
        .mdrOut     (mdrOut),
        .pcOut      (pcOut),
        .zLowOut    (zLowOut),
        .zHighOut   (zHighOut),
        .loOut      (loOut),
        .hiOut      (hiOut),
        .regDrive   (regDrive),
        .regWord    (regWord),
        .hiWord     (hiWord),
        .loWord     (loWord),
        .zHighWord  (zHighWord),
        .zLowWord   (zLowWord),
        .pcWord     (pcWord),
        .mdrWord    (mdrWord),
        .inPortWord (inPortWord),
        .constWord  (constWord),
        .busWord    (busData)
    );

endmodule

//--- hdl/busMultiplexer.sv
module busMultiplexer (
    input  logic               cOut,
    input  logic               inPortOut,
    input  logic               mdrOut,
    input  logic               pcOut,
    input  logic               zLowOut,
    input  logic               zHighOut,
    input  logic               loOut,
    input  logic               hiOut,
    input  logic               regDrive,
    input  datapathPkg::word_t regWord,
    input  datapathPkg::word_t hiWord,
    input  datapathPkg::word_t loWord,
    input  datapathPkg::word_t zHighWord,
    input  datapathPkg::word_t zLowWord,
    input  datapathPkg::word_t pcWord,
    input  datapathPkg::word_t mdrWord,
    input  datapathPkg::word_t inPortWord,
    input  datapathPkg::word_t constWord,
    output datapathPkg::word_t busWord
);

    datapathPkg::busCode_t busCode;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // priority encoder, higher code wins
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the register file has already picked its register, so one code stands for all of them
    always_comb
    begin
        if (cOut)
            busCode = datapathPkg::busConst;
        else if (inPortOut)
            busCode = datapathPkg::busInPort;
        else if (mdrOut)
            busCode = datapathPkg::busMdr;
        else if (pcOut)
            busCode = datapathPkg::busPc;
        else if (zLowOut)
            busCode = datapathPkg::busZLow;
        else if (zHighOut)
            busCode = datapathPkg::busZHigh;
        else if (loOut)
            busCode = datapathPkg::busLo;
        else if (hiOut)
            busCode = datapathPkg::busHi;
        else if (regDrive)
            busCode = datapathPkg::busR0;
        else
            busCode = datapathPkg::busConst;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // word selector
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        case (busCode)
            datapathPkg::busR0:     busWord = regWord;
            datapathPkg::busHi:     busWord = hiWord;
            datapathPkg::busLo:     busWord = loWord;
            datapathPkg::busZHigh:  busWord = zHighWord;
            datapathPkg::busZLow:   busWord = zLowWord;
            datapathPkg::busPc:     busWord = pcWord;
            datapathPkg::busMdr:    busWord = mdrWord;
            datapathPkg::busInPort: busWord = inPortWord;
            default:                busWord = constWord;
        endcase
    end

endmodule

//--- hdl/arithmeticUnit.sv
module arithmeticUnit (
    input  datapathPkg::aluOp_t     aluOp,
    input  datapathPkg::word_t      yWord,
    input  datapathPkg::word_t      busWord,
    output datapathPkg::wideWord_t  aluResult
);

    logic [4:0]             shiftAmount;
    logic signed [63:0]     product;
    logic [63:0]            rotateRight;
    logic [63:0]            rotateLeft;
    datapathPkg::word_t     shortResult;

    assign shiftAmount = busWord[4:0];

    // both operands are signed, so they extend to 64 bits before the multiply
    assign product = $signed(yWord) * $signed(busWord);

    // rotating a doubled word leaves the wrapped bits in the wanted half
    assign rotateRight = {yWord, yWord} >> shiftAmount;
    assign rotateLeft  = {yWord, yWord} << shiftAmount;

    always_comb
    begin
        case (aluOp)
            datapathPkg::opAdd:
                shortResult = yWord + busWord;
            datapathPkg::opSub:
                shortResult = yWord - busWord;
            datapathPkg::opAnd:
                shortResult = yWord & busWord;
            datapathPkg::opOr:
                shortResult = yWord | busWord;
            datapathPkg::opShr:
                shortResult = yWord >> shiftAmount;
            datapathPkg::opShra:
                shortResult = $signed(yWord) >>> shiftAmount;
            datapathPkg::opShl:
                shortResult = yWord << shiftAmount;
            datapathPkg::opRor:
                shortResult = rotateRight[31:0];
            datapathPkg::opRol:
                shortResult = rotateLeft[63:32];
            datapathPkg::opNeg:
                shortResult = -busWord;
            datapathPkg::opNot:
                shortResult = ~busWord;
            default:
                shortResult = '0;
        endcase
    end

    // only mul fills the upper half with real data
    always_comb
    begin
        if (aluOp == datapathPkg::opMul)
            aluResult = product;
        else
            aluResult = {{32{shortResult[31]}}, shortResult};
    end

endmodule

//--- hdl/specialRegisters.sv
module specialRegisters (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    hiIn,
    input  logic                    loIn,
    input  logic                    yIn,
    input  logic                    zIn,
    input  logic                    pcIn,
    input  logic                    mdrIn,
    input  logic                    irIn,
    input  logic                    read,
    input  logic                    inPortStrobe,
    input  datapathPkg::word_t      busWord,
    input  datapathPkg::word_t      memDataIn,
    input  datapathPkg::word_t      inPortData,
    input  datapathPkg::wideWord_t  aluResult,
    output datapathPkg::word_t      hiWord,
    output datapathPkg::word_t      loWord,
    output datapathPkg::word_t      zHighWord,
    output datapathPkg::word_t      zLowWord,
    output datapathPkg::word_t      pcWord,
    output datapathPkg::word_t      mdrWord,
    output datapathPkg::word_t      inPortWord,
    output datapathPkg::word_t      yWord,
    output datapathPkg::word_t      constWord,
    output datapathPkg::instrWord_t irWord
);

    datapathPkg::wideWord_t zReg;
    logic [18:0]            constField;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus-loaded registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            hiWord <= '0;
            loWord <= '0;
            yWord  <= '0;
            pcWord <= '0;
            irWord <= '0;
        end
        else
        begin
            if (hiIn)
                hiWord <= busWord;
            if (loIn)
                loWord <= busWord;
            if (yIn)
                yWord <= busWord;
            if (pcIn)
                pcWord <= busWord;
            if (irIn)
                irWord <= busWord;
        end
    end

    // Z takes the full 64-bit unit result; MDR prefers memory over the bus
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            zReg       <= '0;
            mdrWord    <= '0;
            inPortWord <= '0;
        end
        else
        begin
            if (zIn)
                zReg <= aluResult;
            if (read)
                mdrWord <= memDataIn;
            else if (mdrIn)
                mdrWord <= busWord;
            if (inPortStrobe)
                inPortWord <= inPortData;
        end
    end

    assign zHighWord = zReg[63:32];
    assign zLowWord  = zReg[31:0];

    assign constField = irWord.iFormat.constant;
    assign constWord  = {{13{constField[18]}}, constField};

endmodule

//--- hdl/registerFile.sv
module registerFile #(
    parameter int regCount = 16
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   rIn,
    input  logic                   rOut,
    input  logic                   gra,
    input  logic                   grb,
    input  logic                   grc,
    input  datapathPkg::instrWord_t irWord,
    input  datapathPkg::word_t     busWord,
    output datapathPkg::word_t     regWord,
    output logic                   regDrive
);

    localparam int indexBits = $clog2(regCount);

    datapathPkg::word_t     regBank [regCount];
    logic [3:0]             fieldIndex;
    logic [indexBits-1:0]   regIndex;
    logic                   anySelect;

    // ra wins over rb, and rb over rc
    always_comb
    begin
        if (gra)
            fieldIndex = irWord.rFormat.ra;
        else if (grb)
            fieldIndex = irWord.rFormat.rb;
        else
            fieldIndex = irWord.rFormat.rc;
    end

    assign anySelect = gra | grb | grc;
    assign regIndex  = fieldIndex[indexBits-1:0];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < regCount; i++)
                regBank[i] <= '0;
        end
        else if (rIn && anySelect)
        begin
            regBank[regIndex] <= busWord;
        end
    end

    assign regWord  = regBank[regIndex];
    assign regDrive = rOut & anySelect;

endmodule

//--- hdl/datapathPkg.sv
package datapathPkg;

    // the instruction format fixes the word width
    localparam int dataWidth = 32;

    typedef logic [dataWidth-1:0]   word_t;
    typedef logic [2*dataWidth-1:0] wideWord_t;

    // one instruction word, read as register fields or as an immediate
    typedef union packed {
        struct packed {
            logic [4:0]  opcode;
            logic [3:0]  ra;
            logic [3:0]  rb;
            logic [3:0]  rc;
            logic [14:0] unused;
        } rFormat;
        struct packed {
            logic [4:0]  opcode;
            logic [3:0]  ra;
            logic [3:0]  rb;
            logic [18:0] constant;
        } iFormat;
    } instrWord_t;

    typedef enum logic [4:0] {
        busR0, busR1, busR2, busR3, busR4, busR5, busR6, busR7,
        busR8, busR9, busR10, busR11, busR12, busR13, busR14, busR15,
        busHi, busLo, busZHigh, busZLow, busPc, busMdr, busInPort, busConst
    } busCode_t;

    typedef enum logic [3:0] {
        opAdd, opSub, opAnd, opOr, opShr, opShra,
        opShl, opRor, opRol, opMul, opNeg, opNot
    } aluOp_t;

endpackage
